/* src/lsu_config.svh */
// Watchdog settings for the load/store bus master.
// LSU_BUS_TIMEOUT must fit in LSU_TIMER_W bits.

`ifndef LSU_CONFIG_SVH
`define LSU_CONFIG_SVH

// Waiting cycles before an access is aborted
`define LSU_BUS_TIMEOUT 16

// Width of the watchdog count
`define LSU_TIMER_W 5

`endif

/* src/lsu_pkg.sv */
// Types shared by the load/store bus master.
// Only word accesses are described; no integrity bits.

`default_nettype none

package lsu_pkg;

  typedef enum logic [1:0] {
    IDLE,
    REQ,
    WAIT_RVALID,
    DONE
  } lsu_state_e;

  // Command as accepted from the command port
  typedef struct packed {
    logic [31:0] addr;
    logic        we;
    logic [3:0]  be;
    logic [31:0] wdata;
  } lsu_req_t;

  // Completion data
  typedef struct packed {
    logic [31:0] rdata;
    logic        err;
  } lsu_rsp_t;

endpackage

`default_nettype wire

/* src/lsu_ctrl_if.sv */
// Control strobes between the FSM, the watchdog and the two data stages.
// All strobes except timer_expired are combinational outputs of the FSM.

`timescale 1ns/100ps
`default_nettype none

interface lsu_ctrl_if (
  input wire logic clk_i
);

  logic req_load;
  logic rsp_load;
  logic timer_run;
  logic timer_clr;
  logic timer_expired;

  modport fsm (
    input  clk_i, timer_expired,
    output req_load, rsp_load, timer_run, timer_clr
  );

  modport timer (
    input  clk_i, timer_run, timer_clr,
    output timer_expired
  );

  modport req (input clk_i, req_load);

  modport rsp (input clk_i, rsp_load);

endinterface

`default_nettype wire

/* src/lsu_fsm.sv */
// Sequencer for one word access at a time on the data bus.
// A watchdog expiry aborts the access and sets a sticky alert until reset.

`timescale 1ns/100ps
`default_nettype none

module lsu_fsm (
  input  wire logic clk_i,
  input  wire logic arst_n_i,
  input  wire logic cmd_valid_i,
  input  wire logic data_gnt_i,
  input  wire logic data_rvalid_i,
  lsu_ctrl_if.fsm   ctrl,
  output logic      busy_o,
  output logic      data_req_o,
  output logic      done_o,
  output logic      alert_major_bus_o
);

  lsu_pkg::lsu_state_e state_q;
  lsu_pkg::lsu_state_e state_d;
  logic                abort;
  logic                alert_q;

  always_comb begin
    state_d        = state_q;
    abort          = 1'b0;
    ctrl.req_load  = 1'b0;
    ctrl.rsp_load  = 1'b0;
    ctrl.timer_run = 1'b0;

    case (state_q)
      lsu_pkg::IDLE: begin
        if (cmd_valid_i) begin
          ctrl.req_load = 1'b1;
          state_d       = lsu_pkg::REQ;
        end
      end

      lsu_pkg::REQ: begin
        // Expiry wins, the request is already withdrawn
        if (ctrl.timer_expired) begin
          abort         = 1'b1;
          ctrl.rsp_load = 1'b1;
          state_d       = lsu_pkg::DONE;
        end else if (data_gnt_i) begin
          state_d = lsu_pkg::WAIT_RVALID;
        end else begin
          ctrl.timer_run = 1'b1;
        end
      end

      lsu_pkg::WAIT_RVALID: begin
        // A late rvalid still completes the access
        if (data_rvalid_i) begin
          ctrl.rsp_load = 1'b1;
          state_d       = lsu_pkg::DONE;
        end else if (ctrl.timer_expired) begin
          abort         = 1'b1;
          ctrl.rsp_load = 1'b1;
          state_d       = lsu_pkg::DONE;
        end else begin
          ctrl.timer_run = 1'b1;
        end
      end

      lsu_pkg::DONE: state_d = lsu_pkg::IDLE;

      default: state_d = lsu_pkg::IDLE;
    endcase
  end

  assign ctrl.timer_clr = (state_d != state_q);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= lsu_pkg::IDLE;
      alert_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (abort) begin
        alert_q <= 1'b1;
      end
    end
  end

  assign busy_o            = (state_q != lsu_pkg::IDLE);
  assign data_req_o        = (state_q == lsu_pkg::REQ) && !ctrl.timer_expired;
  assign done_o            = (state_q == lsu_pkg::DONE);
  assign alert_major_bus_o = alert_q;

endmodule

`default_nettype wire

/* src/lsu_bus_timer.sv */
// Bus watchdog, counts waiting cycles and holds at the timeout value.
// Clear has priority over run.

`timescale 1ns/100ps
`default_nettype none

`include "lsu_config.svh"

module lsu_bus_timer (
  input  wire logic clk_i,
  input  wire logic arst_n_i,
  lsu_ctrl_if.timer ctrl
);

  localparam int unsigned timeout_cnt = `LSU_BUS_TIMEOUT;

  logic [`LSU_TIMER_W-1:0] count_q;

  assign ctrl.timer_expired = (count_q == timeout_cnt[`LSU_TIMER_W-1:0]);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      count_q <= '0;
    end else if (ctrl.timer_clr) begin
      count_q <= '0;
    end else if (ctrl.timer_run && !ctrl.timer_expired) begin
      count_q <= count_q + 1'b1;
    end
  end

endmodule

`default_nettype wire

/* src/lsu_req_stage.sv */
// Request register for the data bus.
// Fields hold from acceptance until the next command is loaded.

`timescale 1ns/100ps
`default_nettype none

module lsu_req_stage (
  input  wire logic              clk_i,
  input  wire logic              arst_n_i,
  lsu_ctrl_if.req                ctrl,
  input  wire lsu_pkg::lsu_req_t cmd_i,
  output logic [31:0]            data_addr_o,
  output logic                   data_we_o,
  output logic [3:0]             data_be_o,
  output logic [31:0]            data_wdata_o
);

  lsu_pkg::lsu_req_t req_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      req_q <= '0;
    end else if (ctrl.req_load) begin
      req_q       <= cmd_i;
      // Word aligned, byte lanes come from be
      req_q.addr  <= {cmd_i.addr[31:2], 2'b00};
    end
  end

  assign data_addr_o  = req_q.addr;
  assign data_we_o    = req_q.we;
  assign data_be_o    = req_q.be;
  assign data_wdata_o = req_q.wdata;

endmodule

`default_nettype wire

/* src/lsu_rsp_stage.sv */
// Response register, holds completion data until the next response.
// rsp_load without rvalid is an abort and returns an error with zero data.

`timescale 1ns/100ps
`default_nettype none

module lsu_rsp_stage (
  input  wire logic        clk_i,
  input  wire logic        arst_n_i,
  lsu_ctrl_if.rsp          ctrl,
  input  wire logic [31:0] data_rdata_i,
  input  wire logic        data_err_i,
  input  wire logic        data_rvalid_i,
  input  wire logic [3:0]  req_be_i,
  input  wire logic        req_we_i,
  output logic [31:0]      done_rdata_o,
  output logic             done_err_o
);

  lsu_pkg::lsu_rsp_t rsp_d;
  lsu_pkg::lsu_rsp_t rsp_q;
  logic [31:0]       masked_rdata;

  always_comb begin
    for (int i = 0; i < 4; i++) begin
      masked_rdata[i*8 +: 8] = req_be_i[i] ? data_rdata_i[i*8 +: 8] : 8'h00;
    end
  end

  always_comb begin
    if (data_rvalid_i) begin
      rsp_d.rdata = req_we_i ? 32'h0 : masked_rdata;
      rsp_d.err   = data_err_i;
    end else begin
      rsp_d.rdata = 32'h0;
      rsp_d.err   = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rsp_q <= '0;
    end else if (ctrl.rsp_load) begin
      rsp_q <= rsp_d;
    end
  end

  assign done_rdata_o = rsp_q.rdata;
  assign done_err_o   = rsp_q.err;

endmodule

`default_nettype wire

/* src/lsu_top.sv */
// Load/store bus master on a req/gnt/rvalid data bus.
// One aligned word access at a time; cmd_valid_i is ignored while busy_o is high.

`timescale 1ns/100ps
`default_nettype none

module lsu_top (
  input  wire logic        clk_i,
  input  wire logic        arst_n_i,

  input  wire logic        cmd_valid_i,
  input  wire logic [31:0] cmd_addr_i,
  input  wire logic        cmd_we_i,
  input  wire logic [3:0]  cmd_be_i,
  input  wire logic [31:0] cmd_wdata_i,
  output logic             busy_o,
  output logic             done_o,
  output logic [31:0]      done_rdata_o,
  output logic             done_err_o,

  output logic             data_req_o,
  input  wire logic        data_gnt_i,
  input  wire logic        data_rvalid_i,
  output logic [31:0]      data_addr_o,
  output logic             data_we_o,
  output logic [3:0]       data_be_o,
  output logic [31:0]      data_wdata_o,
  input  wire logic [31:0] data_rdata_i,
  input  wire logic        data_err_i,

  output logic             alert_major_bus_o
);

  lsu_pkg::lsu_req_t cmd_req;

  assign cmd_req = '{addr: cmd_addr_i, we: cmd_we_i, be: cmd_be_i, wdata: cmd_wdata_i};

  lsu_ctrl_if ctrl_if (.clk_i(clk_i));

  lsu_fsm lsu_fsm_inst (
    .clk_i             (clk_i            ),
    .arst_n_i          (arst_n_i         ),
    .cmd_valid_i       (cmd_valid_i      ),
    .data_gnt_i        (data_gnt_i       ),
    .data_rvalid_i     (data_rvalid_i    ),
    .ctrl              (ctrl_if.fsm      ),
    .busy_o            (busy_o           ),
    .data_req_o        (data_req_o       ),
    .done_o            (done_o           ),
    .alert_major_bus_o (alert_major_bus_o)
  );

  lsu_bus_timer lsu_bus_timer_inst (
    .clk_i    (clk_i        ),
    .arst_n_i (arst_n_i     ),
    .ctrl     (ctrl_if.timer)
  );

  lsu_req_stage lsu_req_stage_inst (
    .clk_i        (clk_i       ),
    .arst_n_i     (arst_n_i    ),
    .ctrl         (ctrl_if.req ),
    .cmd_i        (cmd_req     ),
    .data_addr_o  (data_addr_o ),
    .data_we_o    (data_we_o   ),
    .data_be_o    (data_be_o   ),
    .data_wdata_o (data_wdata_o)
  );

  // Held request fields qualify the response
  lsu_rsp_stage lsu_rsp_stage_inst (
    .clk_i         (clk_i        ),
    .arst_n_i      (arst_n_i     ),
    .ctrl          (ctrl_if.rsp  ),
    .data_rdata_i  (data_rdata_i ),
    .data_err_i    (data_err_i   ),
    .data_rvalid_i (data_rvalid_i),
    .req_be_i      (data_be_o    ),
    .req_we_i      (data_we_o    ),
    .done_rdata_o  (done_rdata_o ),
    .done_err_o    (done_err_o   )
  );

endmodule

`default_nettype wire

/* test/lsu_tb_top.sv */
// Directed testbench for lsu_top with a 16-word memory responder on the data bus.
// Grant and rvalid delays are drawn from an LFSR with a fixed seed.

`timescale 1ns/100ps
`default_nettype none

module lsu_tb_top;

  localparam logic [15:0] lfsr_seed = 16'd33843;

  logic        clk_i, arst_n_i, cmd_valid_i, cmd_we_i;
  logic [31:0] cmd_addr_i, cmd_wdata_i;
  logic [3:0]  cmd_be_i;
  logic        busy_o, done_o, done_err_o, alert_major_bus_o;
  logic [31:0] done_rdata_o;
  logic        data_req_o, data_gnt_i, data_rvalid_i, data_we_o, data_err_i;
  logic [31:0] data_addr_o, data_wdata_o, data_rdata_i;
  logic [3:0]  data_be_o;

  logic [31:0] mem [16];
  logic [31:0] model_mem [16];
  logic [15:0] lfsr = lfsr_seed;
  int          gnt_bits = 2;
  logic        stall = 1'b0;
  logic        inject_err = 1'b0;
  int          grants = 0;
  int          checks = 0;
  int          errors = 0;

  lsu_top lsu_top_inst (.*);

  always #50 clk_i = ~clk_i;

  task automatic step();
    @(posedge clk_i);
    #1;
  endtask

  // Taps 16, 14, 13, 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic take_bits(input int n, output int val);
    val = 0;
    repeat (n) begin
      lfsr = lfsr_next(lfsr);
      val  = val * 2 + int'(lfsr[0]);
    end
  endtask

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      $display("Mismatch at %0t: %s is %h, expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  function automatic logic [31:0] byte_mask(input logic [3:0] be);
    return {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
  endfunction

  task automatic apply_reset();
    arst_n_i = 1'b0;
    repeat (3) step();
    arst_n_i = 1'b1;
  endtask

  task automatic compare_mem();
    for (int i = 0; i < 16; i++) begin
      check_value($sformatf("mem[%0d]", i), mem[i], model_mem[i]);
    end
  endtask

  // Issue one command, wait for done_o and check the completion
  task automatic run_cmd(input logic [31:0] addr, input logic we, input logic [3:0] be,
                         input logic [31:0] wdata, input logic exp_err);
    logic [3:0]  idx;
    logic [31:0] m;
    int          n;
    idx         = addr[5:2];
    m           = byte_mask(be);
    cmd_valid_i = 1'b1;
    cmd_addr_i  = addr;
    cmd_we_i    = we;
    cmd_be_i    = be;
    cmd_wdata_i = wdata;
    step();
    cmd_valid_i = 1'b0;
    check_value("data_req_o", 32'(data_req_o), 32'h1);
    check_value("busy_o", 32'(busy_o), 32'h1);
    check_value("data_addr_o", data_addr_o, addr & ~32'h3);
    n = 0;
    while (!done_o && n < 100) begin
      step();
      n++;
    end
    if (!done_o) begin
      $display("Timeout at %0t: done_o did not rise", $time);
      errors++;
    end else begin
      check_value("busy_o", 32'(busy_o), 32'h1);
      check_value("done_err_o", 32'(done_err_o), 32'(exp_err));
      if (!exp_err) begin
        check_value("done_rdata_o", done_rdata_o, we ? 32'h0 : model_mem[idx] & m);
        if (we) begin
          model_mem[idx] = (model_mem[idx] & ~m) | (wdata & m);
        end
      end
    end
    step();
    check_value("done_o", 32'(done_o), 32'h0);
    check_value("busy_o", 32'(busy_o), 32'h0);
  endtask

  // Memory model that grants after a random delay and gives rvalid 1 or 2 cycles later
  initial begin : responder
    logic [31:0] addr_h;
    logic [31:0] wdata_h;
    logic [31:0] m;
    logic        we_h;
    logic [3:0]  be_h;
    int          wait_n;
    int          rv_n;
    data_gnt_i    = 1'b0;
    data_rvalid_i = 1'b0;
    data_rdata_i  = '0;
    data_err_i    = 1'b0;
    forever begin
      step();
      if (data_req_o === 1'b1) begin
        addr_h  = data_addr_o;
        we_h    = data_we_o;
        be_h    = data_be_o;
        wdata_h = data_wdata_o;
        check_value("data_addr_o[1:0]", 32'(addr_h[1:0]), 32'h0);
        if (stall) begin
          wait_n = 40;
        end else begin
          take_bits(gnt_bits, wait_n);
        end
        while (wait_n > 0 && data_req_o) begin
          step();
          wait_n--;
          if (data_req_o) begin
            check_value("data_addr_o", data_addr_o, addr_h);
            check_value("data_we_o", 32'(data_we_o), 32'(we_h));
            check_value("data_be_o", 32'(data_be_o), 32'(be_h));
            check_value("data_wdata_o", data_wdata_o, wdata_h);
          end
        end
        if (data_req_o && stall) begin
          $display("Error at %0t: stalled request was never withdrawn", $time);
          errors++;
        end else if (data_req_o) begin
          data_gnt_i = 1'b1;
          step();
          data_gnt_i = 1'b0;
          grants++;
          check_value("data_req_o", 32'(data_req_o), 32'h0);
          take_bits(1, rv_n);
          if (rv_n != 0) begin
            step();
          end
          data_rvalid_i = 1'b1;
          data_rdata_i  = mem[addr_h[5:2]];
          data_err_i    = inject_err;
          if (we_h && !inject_err) begin
            m = byte_mask(be_h);
            mem[addr_h[5:2]] = (mem[addr_h[5:2]] & ~m) | (wdata_h & m);
          end
          step();
          data_rvalid_i = 1'b0;
          data_err_i    = 1'b0;
        end
      end
    end
  end

  task automatic test_reset_state();
    check_value("data_req_o", 32'(data_req_o), 32'h0);
    check_value("done_o", 32'(done_o), 32'h0);
    check_value("busy_o", 32'(busy_o), 32'h0);
    check_value("alert_major_bus_o", 32'(alert_major_bus_o), 32'h0);
  endtask

  task automatic test_store_load();
    run_cmd(32'h0000_000e, 1'b1, 4'hf, 32'h1234_5678, 1'b0);
    run_cmd(32'h0000_000c, 1'b0, 4'hf, 32'h0, 1'b0);
    run_cmd(32'h0000_000d, 1'b0, 4'b0101, 32'h0, 1'b0);
    run_cmd(32'h0000_0020, 1'b1, 4'b0110, 32'hcafe_f00d, 1'b0);
    run_cmd(32'h0000_0020, 1'b0, 4'hf, 32'h0, 1'b0);
  endtask

  task automatic test_backpressure();
    int g0;
    g0       = grants;
    gnt_bits = 3;
    for (int i = 0; i < 8; i++) begin
      run_cmd(32'(i * 8 + i % 4), i[0], 4'hf ^ 4'(i), 32'h0101_0101 * i, 1'b0);
    end
    gnt_bits = 2;
    check_value("grant count", 32'(grants - g0), 32'd8);
  endtask

  task automatic test_busy_guard();
    int g0;
    int n;
    g0          = grants;
    cmd_valid_i = 1'b1;
    cmd_addr_i  = 32'h0000_0008;
    cmd_we_i    = 1'b0;
    cmd_be_i    = 4'hf;
    step();
    // Stray stores offered while busy
    cmd_we_i    = 1'b1;
    cmd_addr_i  = 32'h0000_0014;
    cmd_wdata_i = 32'hbad0_bad0;
    n = 0;
    while (!done_o && n < 100) begin
      check_value("busy_o", 32'(busy_o), 32'h1);
      cmd_valid_i = ~cmd_valid_i;
      step();
      n++;
    end
    cmd_valid_i = 1'b0;
    if (!done_o) begin
      $display("Timeout at %0t: done_o did not rise while busy", $time);
      errors++;
    end
    step();
    check_value("grant count", 32'(grants - g0), 32'd1);
    compare_mem();
  endtask

  task automatic test_bus_error();
    inject_err = 1'b1;
    run_cmd(32'h0000_0004, 1'b0, 4'hf, 32'h0, 1'b1);
    inject_err = 1'b0;
    check_value("alert_major_bus_o", 32'(alert_major_bus_o), 32'h0);
  endtask

  task automatic test_watchdog();
    stall = 1'b1;
    run_cmd(32'h0000_001c, 1'b1, 4'hf, 32'h5555_aaaa, 1'b1);
    stall = 1'b0;
    check_value("done_rdata_o", done_rdata_o, 32'h0);
    check_value("alert_major_bus_o", 32'(alert_major_bus_o), 32'h1);
    compare_mem();
    run_cmd(32'h0000_001c, 1'b0, 4'hf, 32'h0, 1'b0);
    check_value("alert_major_bus_o", 32'(alert_major_bus_o), 32'h1);
    apply_reset();
    test_reset_state();
  endtask

  initial begin
    clk_i       = 1'b0;
    arst_n_i    = 1'b0;
    cmd_valid_i = 1'b0;
    cmd_addr_i  = '0;
    cmd_we_i    = 1'b0;
    cmd_be_i    = '0;
    cmd_wdata_i = '0;
    for (int i = 0; i < 16; i++) begin
      mem[i]       = 32'h5a00_0000 ^ (32'(i) * 32'h0001_0203);
      model_mem[i] = mem[i];
    end
    apply_reset();
    test_reset_state();
    test_store_load();
    test_backpressure();
    test_busy_guard();
    test_bus_error();
    test_watchdog();
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+src
src/lsu_pkg.sv
src/lsu_ctrl_if.sv
src/lsu_fsm.sv
src/lsu_bus_timer.sv
src/lsu_req_stage.sv
src/lsu_rsp_stage.sv
src/lsu_top.sv
test/lsu_tb_top.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the lsu_top testbench with Verilator.

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -f filelist.f --top-module lsu_tb_top -o lsu_sim; then
  echo "Verilator build failed"
  exit 1
fi

if ! sim_out=$(./obj_dir/lsu_sim); then
  printf '%s\n' "$sim_out"
  echo "Simulation did not exit cleanly"
  exit 1
fi
printf '%s\n' "$sim_out"

if printf '%s\n' "$sim_out" | grep -qx "TESTS PASSED"; then
  exit 0
fi
echo "Simulation reported failure"
exit 1
